// File: wwr_params.svh
//////////////////////////////////////////////////
// word width, bus width and address macros
// for the word repacking buffer
//////////////////////////////////////////////////

`ifndef WWR_PARAMS_SVH
`define WWR_PARAMS_SVH

// bits per stored word
`define WWR_WORD_WIDTH 64

// words per bus, the lane rotation is built for exactly four
`define WWR_NUM_WORDS 4

// word address width, 512 words in total
`define WWR_ADDR_WIDTH 9

// total words of storage across all lanes
`define WWR_DEPTH (1 << `WWR_ADDR_WIDTH)

// one bus of slack so unused write lanes never land on unread words
`define WWR_CAPACITY (`WWR_DEPTH - `WWR_NUM_WORDS)

`endif

// File: wwr_pkg.sv
//////////////////////////////////////////////////
// word, bus, address and count types plus the
// command and response structs of the buffer
//////////////////////////////////////////////////

`include "wwr_params.svh"

package wwr_pkg;

	// address to data, two for rows, two in lane memory, two for rotation
	localparam int unsigned WWR_RD_LATENCY = 6;

	typedef logic [`WWR_WORD_WIDTH-1:0] word_t;

	// word 0 sits in the low bits
	typedef word_t [`WWR_NUM_WORDS-1:0] bus_t;

	typedef logic [`WWR_ADDR_WIDTH-1:0] waddr_t;

	// row inside one lane memory
	typedef logic [`WWR_ADDR_WIDTH-3:0] row_t;

	// number of words in a chunk, 1 to 4
	typedef logic [2:0] cnt_t;

	// spare top bit keeps an overfilled count visible
	typedef logic [`WWR_ADDR_WIDTH:0] fill_t;

	typedef row_t [`WWR_NUM_WORDS-1:0] lane_rows_t;

	typedef struct packed {
		logic valid;
		cnt_t count;
		bus_t data;
	} wr_cmd_t;

	typedef struct packed {
		logic valid;
		cnt_t count;
	} rd_cmd_t;

	typedef struct packed {
		logic valid;
		cnt_t count;
		bus_t data;
	} rd_resp_t;

endpackage

// File: lane_ram.sv
//////////////////////////////////////////////////
// single lane simple dual port memory with
// registered read row and registered output
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "wwr_params.svh"

module lane_ram
	import wwr_pkg::*;
(
	input  logic  clk,
	input  logic  we,
	input  row_t  wr_row,
	input  word_t wr_data,
	input  row_t  rd_row,
	output word_t rd_data
);

	localparam int unsigned ROWS = `WWR_DEPTH / `WWR_NUM_WORDS;

	word_t mem [ROWS];
	row_t  rd_row_q;
	word_t rd_data_q;

	// read takes two edges, row register then output register
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_row] <= wr_data;
		end
		rd_row_q  <= rd_row;
		rd_data_q <= mem[rd_row_q];
	end

	assign rd_data = rd_data_q;

endmodule

// File: word_rotator.sv
//////////////////////////////////////////////////
// two stage pipelined word rotation of a bus
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "wwr_params.svh"

module word_rotator
	import wwr_pkg::*;
#(
	// set: output word i takes input word i+amount
	parameter bit ROTATE_DOWN = 1'b0
)
(
	input  logic       clk,
	input  logic       arst,
	input  logic [1:0] amount,
	input  bus_t       din,
	output bus_t       dout
);

	bus_t stage1_q;
	bus_t stage2_q;
	logic amt0_q;

	function automatic bus_t rotate(input bus_t b, input int unsigned n);
		bus_t r;
		for (int i = 0; i < `WWR_NUM_WORDS; i++) begin
			if (ROTATE_DOWN) begin
				r[i] = b[(i + n) % `WWR_NUM_WORDS];
			end else begin
				r[i] = b[(i + `WWR_NUM_WORDS - n) % `WWR_NUM_WORDS];
			end
		end
		return r;
	endfunction

	// coarse step by two words, low amount bit follows to the next stage
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			stage1_q <= '0;
			amt0_q   <= 1'b0;
		end else begin
			stage1_q <= amount[1] ? rotate(din, 2) : din;
			amt0_q   <= amount[0];
		end
	end

	// fine step by one word
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			stage2_q <= '0;
		end else begin
			stage2_q <= amt0_q ? rotate(stage1_q, 1) : stage1_q;
		end
	end

	assign dout = stage2_q;

endmodule

// File: lane_addr_gen.sv
//////////////////////////////////////////////////
// word address to per lane row indices and a
// matching rotation amount, two stages
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "wwr_params.svh"

module lane_addr_gen
	import wwr_pkg::*;
(
	input  logic       clk,
	input  logic       arst,
	input  waddr_t     addr,
	output lane_rows_t rows,
	output logic [1:0] amount
);

	row_t                     row_q;
	row_t                     row_plus_q;
	logic [`WWR_NUM_WORDS-1:0] mask_q;
	logic [1:0]               amount_q;
	lane_rows_t               rows_q;
	logic [1:0]               amount_qq;

	//////////////////////////////////////////////////
	// stage one
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			row_q      <= '0;
			row_plus_q <= '0;
			mask_q     <= '0;
			amount_q   <= 2'd0;
		end else begin
			row_q      <= addr[`WWR_ADDR_WIDTH-1:2];
			row_plus_q <= addr[`WWR_ADDR_WIDTH-1:2] + 1'b1;
			amount_q   <= addr[1:0];
			// lanes below the start offset wrap into the next row
			case (addr[1:0])
				2'd0: mask_q <= 4'b0000;
				2'd1: mask_q <= 4'b0001;
				2'd2: mask_q <= 4'b0011;
				2'd3: mask_q <= 4'b0111;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// stage two
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			rows_q    <= '0;
			amount_qq <= 2'd0;
		end else begin
			for (int l = 0; l < `WWR_NUM_WORDS; l++) begin
				rows_q[l] <= mask_q[l] ? row_plus_q : row_q;
			end
			amount_qq <= amount_q;
		end
	end

	assign rows   = rows_q;
	assign amount = amount_qq;

endmodule

// File: wide_word_ram.sv
//////////////////////////////////////////////////
// word addressed wide RAM built from four lane
// memories with rotation on both data paths
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "wwr_params.svh"

module wide_word_ram
	import wwr_pkg::*;
(
	input  logic   clk,
	input  logic   arst,
	input  logic   we,
	input  waddr_t wr_addr,
	input  bus_t   wr_data,
	input  waddr_t rd_addr,
	output bus_t   rd_data
);

	lane_rows_t wr_rows;
	lane_rows_t rd_rows;
	logic [1:0] rd_amount;
	logic [1:0] rd_amount_d1;
	logic [1:0] rd_amount_d2;
	bus_t       wr_rot;
	bus_t       ram_bus;
	logic       we_d1;
	logic       we_d2;

	//////////////////////////////////////////////////
	// write side
	//////////////////////////////////////////////////

	lane_addr_gen u_wr_addr_gen (
		.clk    (clk),
		.arst   (arst),
		.addr   (wr_addr),
		.rows   (wr_rows),
		.amount ()
	);

	// data word 0 moves up to the lane of the start address
	word_rotator #(.ROTATE_DOWN(1'b0)) u_wr_rot (
		.clk    (clk),
		.arst   (arst),
		.amount (wr_addr[1:0]),
		.din    (wr_data),
		.dout   (wr_rot)
	);

	// enable follows rows and data through two stages
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			we_d1 <= 1'b0;
			we_d2 <= 1'b0;
		end else begin
			we_d1 <= we;
			we_d2 <= we_d1;
		end
	end

	//////////////////////////////////////////////////
	// storage and read side
	//////////////////////////////////////////////////

	lane_addr_gen u_rd_addr_gen (
		.clk    (clk),
		.arst   (arst),
		.addr   (rd_addr),
		.rows   (rd_rows),
		.amount (rd_amount)
	);

	for (genvar l = 0; l < `WWR_NUM_WORDS; l++) begin : g_lane
		lane_ram u_ram (
			.clk     (clk),
			.we      (we_d2),
			.wr_row  (wr_rows[l]),
			.wr_data (wr_rot[l]),
			.rd_row  (rd_rows[l]),
			.rd_data (ram_bus[l])
		);
	end

	// amount waits out the two cycle lane memory read
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			rd_amount_d1 <= 2'd0;
			rd_amount_d2 <= 2'd0;
		end else begin
			rd_amount_d1 <= rd_amount;
			rd_amount_d2 <= rd_amount_d1;
		end
	end

	// oldest requested word comes back in word 0
	word_rotator #(.ROTATE_DOWN(1'b1)) u_rd_rot (
		.clk    (clk),
		.arst   (arst),
		.amount (rd_amount_d2),
		.din    (ram_bus),
		.dout   (rd_data)
	);

endmodule

// File: write_packer.sv
//////////////////////////////////////////////////
// write pointer, places each chunk at the next
// free word address
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "wwr_params.svh"

module write_packer
	import wwr_pkg::*;
(
	input  logic    clk,
	input  logic    arst,
	input  wr_cmd_t wr_cmd,
	output logic    we,
	output waddr_t  wr_addr,
	output bus_t    wr_data
);

	waddr_t wr_ptr;

	// pointer wraps naturally at the power of two depth
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			wr_ptr <= '0;
		end else if (wr_cmd.valid) begin
			wr_ptr <= wr_ptr + waddr_t'(wr_cmd.count);
		end
	end

	assign we      = wr_cmd.valid;
	assign wr_addr = wr_ptr;
	assign wr_data = wr_cmd.data;

endmodule

// File: read_unpacker.sv
//////////////////////////////////////////////////
// read pointer and the response valid and count
// delay line matched to the RAM read latency
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "wwr_params.svh"

module read_unpacker
	import wwr_pkg::*;
(
	input  logic     clk,
	input  logic     arst,
	input  rd_cmd_t  rd_cmd,
	output waddr_t   rd_addr,
	input  bus_t     ram_data,
	output rd_resp_t rd_resp
);

	waddr_t  rd_ptr;
	rd_cmd_t cmd_pipe [WWR_RD_LATENCY];

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			rd_ptr <= '0;
		end else if (rd_cmd.valid) begin
			rd_ptr <= rd_ptr + waddr_t'(rd_cmd.count);
		end
	end

	assign rd_addr = rd_ptr;

	// one stage per cycle of RAM latency
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			for (int i = 0; i < WWR_RD_LATENCY; i++) begin
				cmd_pipe[i] <= '0;
			end
		end else begin
			cmd_pipe[0] <= rd_cmd;
			for (int i = 1; i < WWR_RD_LATENCY; i++) begin
				cmd_pipe[i] <= cmd_pipe[i-1];
			end
		end
	end

	always_comb begin
		rd_resp.valid = cmd_pipe[WWR_RD_LATENCY-1].valid;
		rd_resp.count = cmd_pipe[WWR_RD_LATENCY-1].count;
		rd_resp.data  = ram_data;
	end

endmodule

// File: fill_tracker.sv
//////////////////////////////////////////////////
// occupancy in words with sticky overflow and
// underflow flags
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "wwr_params.svh"

module fill_tracker
	import wwr_pkg::*;
(
	input  logic    clk,
	input  logic    arst,
	input  wr_cmd_t wr_cmd,
	input  rd_cmd_t rd_cmd,
	output fill_t   fill,
	output logic    overflow,
	output logic    underflow
);

	fill_t fill_q;
	fill_t wr_n;
	fill_t rd_n;
	fill_t fill_plus;
	fill_t fill_next;
	logic  over_now;
	logic  under_now;

	always_comb begin
		wr_n      = wr_cmd.valid ? fill_t'(wr_cmd.count) : '0;
		rd_n      = rd_cmd.valid ? fill_t'(rd_cmd.count) : '0;
		fill_plus = fill_q + wr_n;
		under_now = rd_n > fill_plus;
		// a read past the end just empties the count
		fill_next = under_now ? '0 : fill_plus - rd_n;
		over_now  = fill_next > fill_t'(`WWR_CAPACITY);
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			fill_q    <= '0;
			overflow  <= 1'b0;
			underflow <= 1'b0;
		end else begin
			fill_q <= fill_next;
			if (over_now) begin
				overflow <= 1'b1;
			end
			if (under_now) begin
				underflow <= 1'b1;
			end
		end
	end

	assign fill = fill_q;

endmodule

// File: word_pack_buffer.sv
//////////////////////////////////////////////////
// top level of the word repacking buffer
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "wwr_params.svh"

module word_pack_buffer
	import wwr_pkg::*;
(
	input  logic     clk,
	input  logic     arst,
	input  wr_cmd_t  wr_cmd,
	input  rd_cmd_t  rd_cmd,
	output rd_resp_t rd_resp,
	output fill_t    fill,
	output logic     overflow,
	output logic     underflow
);

	logic   ram_we;
	waddr_t ram_wr_addr;
	bus_t   ram_wr_data;
	waddr_t ram_rd_addr;
	bus_t   ram_rd_data;

	write_packer u_write_packer (
		.clk     (clk),
		.arst    (arst),
		.wr_cmd  (wr_cmd),
		.we      (ram_we),
		.wr_addr (ram_wr_addr),
		.wr_data (ram_wr_data)
	);

	read_unpacker u_read_unpacker (
		.clk      (clk),
		.arst     (arst),
		.rd_cmd   (rd_cmd),
		.rd_addr  (ram_rd_addr),
		.ram_data (ram_rd_data),
		.rd_resp  (rd_resp)
	);

	fill_tracker u_fill_tracker (
		.clk       (clk),
		.arst      (arst),
		.wr_cmd    (wr_cmd),
		.rd_cmd    (rd_cmd),
		.fill      (fill),
		.overflow  (overflow),
		.underflow (underflow)
	);

	wide_word_ram u_ram (
		.clk     (clk),
		.arst    (arst),
		.we      (ram_we),
		.wr_addr (ram_wr_addr),
		.wr_data (ram_wr_data),
		.rd_addr (ram_rd_addr),
		.rd_data (ram_rd_data)
	);

endmodule

// File: word_pack_buffer_assertions.sv
//////////////////////////////////////////////////
// concurrent checks on the buffer top level,
// bound into word_pack_buffer
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "wwr_params.svh"

module word_pack_buffer_assertions
	import wwr_pkg::*;
(
	input logic     clk,
	input logic     arst,
	input wr_cmd_t  wr_cmd,
	input rd_cmd_t  rd_cmd,
	input rd_resp_t rd_resp,
	input logic     overflow,
	input logic     underflow
);

	// response strobe is the read strobe seen through the full latency
	a_resp_latency: assert property (
		@(posedge clk) disable iff (arst)
		rd_resp.valid == $past(rd_cmd.valid, WWR_RD_LATENCY)
	) else $error("rd_resp valid is not rd_cmd valid delayed by %0d", WWR_RD_LATENCY);

	a_wr_count: assert property (
		@(posedge clk) disable iff (arst)
		wr_cmd.valid |-> (wr_cmd.count != 3'd0 && wr_cmd.count <= 3'd4)
	) else $error("write command count %0d out of range", wr_cmd.count);

	a_rd_count: assert property (
		@(posedge clk) disable iff (arst)
		rd_cmd.valid |-> (rd_cmd.count != 3'd0 && rd_cmd.count <= 3'd4)
	) else $error("read command count %0d out of range", rd_cmd.count);

	// error flags only clear through reset
	a_overflow_sticky: assert property (
		@(posedge clk) disable iff (arst)
		!$fell(overflow)
	) else $error("overflow dropped without a reset");

	a_underflow_sticky: assert property (
		@(posedge clk) disable iff (arst)
		!$fell(underflow)
	) else $error("underflow dropped without a reset");

endmodule

bind word_pack_buffer word_pack_buffer_assertions u_assertions (
	.clk       (clk),
	.arst      (arst),
	.wr_cmd    (wr_cmd),
	.rd_cmd    (rd_cmd),
	.rd_resp   (rd_resp),
	.overflow  (overflow),
	.underflow (underflow)
);

// File: tb_word_pack_buffer.sv
//////////////////////////////////////////////////
// testbench for the word repacking buffer
// clock, reset, stimulus, reference queue model
// and compare tasks
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "wwr_params.svh"

module tb_word_pack_buffer
	import wwr_pkg::*;
();

	localparam int RESP_DELAY = 6;
	localparam int WORD_AGE   = 4;
	localparam int TIMEOUT    = 200;

	logic     clk;
	logic     arst;
	wr_cmd_t  wr_cmd;
	rd_cmd_t  rd_cmd;
	rd_resp_t rd_resp;
	fill_t    fill;
	logic     overflow;
	logic     underflow;

	integer   seed;
	int       cycle = 0;
	int       words_read;
	int       words_written;
	bit       fill_check_en;
	bit       resp_check_en;
	// reference model holds words in write order with the cycle they were driven
	word_t    ref_q[$];
	int       age_q[$];
	rd_resp_t exp_q[$];
	int       exp_cycle_q[$];

	word_pack_buffer uut (
		.clk       (clk),
		.arst      (arst),
		.wr_cmd    (wr_cmd),
		.rd_cmd    (rd_cmd),
		.rd_resp   (rd_resp),
		.fill      (fill),
		.overflow  (overflow),
		.underflow (underflow)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	//////////////////////////////////////////////////
	// reporting and compare tasks
	//////////////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_resp(input rd_resp_t got, input rd_resp_t want);
		int n;
		n = int'(want.count);
		if (got.count !== want.count) begin
			fail_run($sformatf("MISMATCH rd_resp.count got %h expected %h",
				got.count, want.count));
		end
		// words past the count are undefined
		for (int i = 0; i < n; i++) begin
			if (got.data[i] !== want.data[i]) begin
				fail_run($sformatf("MISMATCH rd_resp.data[%0d] got %h expected %h",
					i, got.data[i], want.data[i]));
			end
		end
	endtask

	task automatic check_fill(input fill_t got, input fill_t want);
		if (got !== want) begin
			fail_run($sformatf("MISMATCH fill got %h expected %h", got, want));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, want));
		end
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// oldest words of the queue come back in word 0 upward
	function automatic rd_resp_t expected_resp(input word_t q[$], input cnt_t n);
		rd_resp_t r;
		r       = '0;
		r.valid = 1'b1;
		r.count = n;
		for (int i = 0; i < int'(n); i++) begin
			r.data[i] = q[i];
		end
		return r;
	endfunction

	function automatic bit words_ready(input int n);
		if (ref_q.size() < n) begin
			return 1'b0;
		end
		return (cycle - age_q[n-1]) >= WORD_AGE;
	endfunction

	function automatic word_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	// one cycle where fill is checked before the new commands go out
	task automatic step(input bit wv, input int wc, input bit rv, input int rc);
		rd_resp_t want;
		@(negedge clk);
		if (fill_check_en) begin
			check_fill(fill, fill_t'(ref_q.size()));
		end
		wr_cmd = '0;
		rd_cmd = '0;
		if (rv) begin
			want = expected_resp(ref_q, cnt_t'(rc));
			exp_q.push_back(want);
			exp_cycle_q.push_back(cycle);
			for (int i = 0; i < rc; i++) begin
				void'(ref_q.pop_front());
				void'(age_q.pop_front());
			end
			words_read += rc;
			rd_cmd.valid = 1'b1;
			rd_cmd.count = cnt_t'(rc);
		end
		if (wv) begin
			wr_cmd.valid = 1'b1;
			wr_cmd.count = cnt_t'(wc);
			for (int i = 0; i < `WWR_NUM_WORDS; i++) begin
				wr_cmd.data[i] = rand_word();
				if (i < wc) begin
					ref_q.push_back(wr_cmd.data[i]);
					age_q.push_back(cycle);
				end
			end
			words_written += wc;
		end
	endtask

	task automatic wait_ready(input int n);
		int t;
		t = 0;
		while (!words_ready(n)) begin
			step(1'b0, 0, 1'b0, 0);
			t++;
			if (t > TIMEOUT) begin
				fail_run("timed out waiting for written words to age");
			end
		end
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		while (exp_q.size() > 0) begin
			step(1'b0, 0, 1'b0, 0);
			t++;
			if (t > TIMEOUT) begin
				fail_run("timed out waiting for read responses");
			end
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		wr_cmd = '0;
		rd_cmd = '0;
		arst   = 1'b1;
		ref_q.delete();
		age_q.delete();
		exp_q.delete();
		exp_cycle_q.delete();
		repeat (10) @(negedge clk);
		arst = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// response checker
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!arst && resp_check_en) begin
			if (rd_resp.valid) begin
				if (exp_q.size() == 0) begin
					fail_run("read response arrived with no read outstanding");
				end else begin
					if (cycle - exp_cycle_q[0] != RESP_DELAY) begin
						fail_run($sformatf("read response came %0d cycles after its read",
							cycle - exp_cycle_q[0]));
					end
					check_resp(rd_resp, exp_q[0]);
					void'(exp_q.pop_front());
					void'(exp_cycle_q.pop_front());
				end
			end else if (exp_q.size() > 0 && cycle - exp_cycle_q[0] >= RESP_DELAY) begin
				fail_run("an expected read response never arrived");
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	initial begin
		int rc;
		int wc;
		int pad;
		bit rv;
		bit wv;
		clk           = 1'b0;
		arst          = 1'b1;
		wr_cmd        = '0;
		rd_cmd        = '0;
		seed          = 88413;
		words_read    = 0;
		words_written = 0;
		fill_check_en = 1'b1;
		resp_check_en = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst = 1'b0;

		// 4-word chunk at every start lane with short chunks to line up the pointer
		for (int off = 0; off < 4; off++) begin
			pad = (off - words_written) & 3;
			if (pad != 0) begin
				step(1'b1, pad, 1'b0, 0);
				wait_ready(pad);
				step(1'b0, 0, 1'b1, pad);
			end
			step(1'b1, 4, 1'b0, 0);
			wait_ready(4);
			step(1'b0, 0, 1'b1, 4);
			wait_drain();
		end

		// random repacking followed by a dense stream that wraps both pointers
		for (int n = 0; n < 1400; n++) begin
			rc = 1 + ($random(seed) & 3);
			wc = 1 + ($random(seed) & 3);
			rv = words_ready(rc);
			wv = (n >= 400 || ($random(seed) & 3) != 0) &&
				(ref_q.size() + wc <= `WWR_CAPACITY);
			step(wv, wc, rv, rc);
		end
		wait_drain();
		// reads that empty the buffer exactly are legal
		check_flag("overflow", overflow, 1'b0);
		check_flag("underflow", underflow, 1'b0);
		if (words_read < 2000) begin
			fail_run("fewer than 2000 words passed through the buffer");
		end

		// overflow once the buffer goes past capacity
		apply_reset();
		for (int i = 0; i < `WWR_CAPACITY / 4; i++) begin
			step(1'b1, 4, 1'b0, 0);
		end
		step(1'b0, 0, 1'b0, 0);
		check_flag("overflow", overflow, 1'b0);
		step(1'b1, 1, 1'b0, 0);
		step(1'b0, 0, 1'b0, 0);
		check_flag("overflow", overflow, 1'b1);
		repeat (5) step(1'b0, 0, 1'b0, 0);
		check_flag("overflow", overflow, 1'b1);
		apply_reset();
		step(1'b0, 0, 1'b0, 0);
		check_flag("overflow", overflow, 1'b0);

		// underflow from a read larger than fill, driven outside the model
		step(1'b1, 2, 1'b0, 0);
		wait_ready(2);
		fill_check_en = 1'b0;
		resp_check_en = 1'b0;
		@(negedge clk);
		wr_cmd       = '0;
		rd_cmd.valid = 1'b1;
		rd_cmd.count = 3'd4;
		@(negedge clk);
		rd_cmd = '0;
		check_flag("underflow", underflow, 1'b1);
		repeat (10) @(negedge clk);
		check_flag("underflow", underflow, 1'b1);
		apply_reset();
		fill_check_en = 1'b1;
		resp_check_en = 1'b1;
		step(1'b0, 0, 1'b0, 0);
		check_flag("underflow", underflow, 1'b0);
		check_flag("overflow", overflow, 1'b0);

		if (exp_q.size() == 0 && fill == '0) begin
			$display("Regression passed");
			$finish;
		end else begin
			fail_run("buffer not empty at the end of the run");
		end
	end

endmodule

// File: sim.f
+incdir+.
wwr_pkg.sv
lane_ram.sv
word_rotator.sv
lane_addr_gen.sv
wide_word_ram.sv
write_packer.sv
read_unpacker.sv
fill_tracker.sv
word_pack_buffer.sv
word_pack_buffer_assertions.sv
tb_word_pack_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the word pack buffer regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module tb_word_pack_buffer -o tb_word_pack_buffer
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/tb_word_pack_buffer
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0
